//--- Bender.yml
package:
  name: icache

sources:
  - design/icache_pkg.sv
  - design/fetch_request.sv
  - design/cache_ways.sv
  - design/refill_ctrl.sv
  - design/icache_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/mem_model.sv
      - tb/icache_tb.sv

//--- all.f
design/icache_pkg.sv
design/fetch_request.sv
design/cache_ways.sv
design/refill_ctrl.sv
design/icache_top.sv
tb/tb_clock.sv
tb/mem_model.sv
tb/icache_tb.sv

//--- design/cache_ways.sv
module cache_ways (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index_a_i,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index_b_i,
    input  icache_pkg::lookup_req_t        lookup_i,
    input  icache_pkg::refill_wr_t         wr_i,
    output icache_pkg::way_hit_t           hit_o
);

    logic [1:0]                    hit_a;
    logic [1:0]                    hit_b;
    logic [icache_pkg::ADDR_W-1:0] word_a [2];
    logic [icache_pkg::ADDR_W-1:0] word_b [2];

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [icache_pkg::LINE_W-1:0] data_mem [icache_pkg::NUM_SETS];
        logic [icache_pkg::TAG_W-1:0]  tag_mem [icache_pkg::NUM_SETS];
        logic [icache_pkg::NUM_SETS-1:0] valid_q;
        logic [icache_pkg::LINE_W-1:0] line_a_q;
        logic [icache_pkg::LINE_W-1:0] line_b_q;
        logic [icache_pkg::TAG_W-1:0]  tag_a_q;
        logic [icache_pkg::TAG_W-1:0]  tag_b_q;
        logic                          valid_a_q;
        logic                          valid_b_q;
        logic                          wr_sel;

        assign wr_sel = wr_i.we && (wr_i.way == 1'(w));

        // port a and port b, read-first
        always_ff @(posedge clk) begin
            if (wr_sel && wr_i.we_a) begin
                data_mem[lookup_i.pair.a.f.index] <= wr_i.line;
                tag_mem[lookup_i.pair.a.f.index]  <= lookup_i.pair.a.f.tag;
            end
            if (wr_sel && wr_i.we_b) begin
                data_mem[lookup_i.pair.b.f.index] <= wr_i.line;
                tag_mem[lookup_i.pair.b.f.index]  <= lookup_i.pair.b.f.tag;
            end
            line_a_q <= data_mem[rd_index_a_i];
            line_b_q <= data_mem[rd_index_b_i];
            tag_a_q  <= tag_mem[rd_index_a_i];
            tag_b_q  <= tag_mem[rd_index_b_i];
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_q <= '0;
            end else begin
                if (wr_sel && wr_i.we_a) begin
                    valid_q[lookup_i.pair.a.f.index] <= 1'b1;
                end
                if (wr_sel && wr_i.we_b) begin
                    valid_q[lookup_i.pair.b.f.index] <= 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            valid_a_q <= valid_q[rd_index_a_i];
            valid_b_q <= valid_q[rd_index_b_i];
        end

        assign hit_a[w] = valid_a_q && (tag_a_q == lookup_i.pair.a.f.tag);
        assign hit_b[w] = valid_b_q && (tag_b_q == lookup_i.pair.b.f.tag);

        assign word_a[w] = line_a_q[lookup_i.pair.a.f.word_sel * icache_pkg::ADDR_W +:
                                    icache_pkg::ADDR_W];
        assign word_b[w] = line_b_q[lookup_i.pair.b.f.word_sel * icache_pkg::ADDR_W +:
                                    icache_pkg::ADDR_W];
    end

    assign hit_o.hit_a  = hit_a;
    assign hit_o.hit_b  = hit_b;
    assign hit_o.data_a = hit_a[1] ? word_a[1] : word_a[0];
    assign hit_o.data_b = hit_b[1] ? word_b[1] : word_b[0];

    // a refilled line must not already live in the other way
    a_no_dup_line: assert property (
        @(posedge clk) disable iff (reset)
        wr_i.we && wr_i.we_a |-> !(wr_i.way ? hit_a[0] : hit_a[1])
    ) else $error("refill would place line in both ways");

endmodule

//--- design/fetch_request.sv
module fetch_request (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               fetch_valid_i,
    input  icache_pkg::fetch_addr_u            pc_i,
    input  logic                               flush_i,
    input  logic                               hold_i,
    output icache_pkg::lookup_req_t            lookup_o,
    output logic [icache_pkg::INDEX_W-1:0]     rd_index_a_o,
    output logic [icache_pkg::INDEX_W-1:0]     rd_index_b_o
);

    icache_pkg::fetch_pair_t new_pair;
    icache_pkg::lookup_req_t lookup_q;
    logic                    accept;

    // second word always requested
    always_comb begin
        new_pair.a     = pc_i;
        new_pair.b.raw = pc_i.raw + 32'd4;
    end

    assign accept = fetch_valid_i && !hold_i;

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            lookup_q.valid <= 1'b0;
        end else if (!hold_i) begin
            lookup_q.valid <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lookup_q.pair <= new_pair;
        end
    end

    assign lookup_o = lookup_q;

    // arrays re-read the pending pair until the miss resolves
    assign rd_index_a_o = hold_i ? lookup_q.pair.a.f.index : new_pair.a.f.index;
    assign rd_index_b_o = hold_i ? lookup_q.pair.b.f.index : new_pair.b.f.index;

    a_lookup_frozen: assert property (
        @(posedge clk) disable iff (reset)
        hold_i && !flush_i |=> $stable(lookup_o)
    ) else $error("lookup request changed while held");

endmodule

//--- design/icache_pkg.sv
package icache_pkg;

    localparam int ADDR_W         = 32;
    localparam int NUM_SETS       = 128;
    localparam int INDEX_W        = 7;
    localparam int TAG_W          = 20;
    localparam int WORDS_PER_LINE = 8;
    localparam int LINE_W         = 256;

    // field view of a fetch address
    typedef struct packed {
        logic [TAG_W-1:0]                  tag;
        logic [INDEX_W-1:0]                index;
        logic [$clog2(WORDS_PER_LINE)-1:0] word_sel;
        logic [1:0]                        offset;
    } addr_fields_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        addr_fields_t      f;
    } fetch_addr_u;

    // slot a is the pc, slot b the next word
    typedef struct packed {
        fetch_addr_u a;
        fetch_addr_u b;
    } fetch_pair_t;

    typedef struct packed {
        logic        valid;
        fetch_pair_t pair;
    } lookup_req_t;

    // hit bit [0] is way 0, [1] is way 1
    typedef struct packed {
        logic [1:0]        hit_a;
        logic [1:0]        hit_b;
        logic [ADDR_W-1:0] data_a;
        logic [ADDR_W-1:0] data_b;
    } way_hit_t;

    typedef struct packed {
        logic              we;
        logic              way;
        logic              we_a;
        logic              we_b;
        logic [LINE_W-1:0] line;
    } refill_wr_t;

    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef enum logic [4:0] {
        state_idle    = 5'b00001,
        state_fill_a  = 5'b00010,
        state_fill_b  = 5'b00100,
        state_deliver = 5'b01000
    } refill_state_e;

endpackage

//--- design/icache_top.sv
module icache_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               fetch_valid_i,
    input  logic [icache_pkg::ADDR_W-1:0]      pc_i,
    input  logic                               flush_i,
    output logic                               stall_o,
    output logic                               inst_valid_o,
    output logic [1:0][icache_pkg::ADDR_W-1:0] inst_o,
    output logic [1:0][icache_pkg::ADDR_W-1:0] inst_pc_o,
    output icache_pkg::mem_req_t               mem_req_o,
    input  logic                               mem_ret_valid_i,
    input  logic [icache_pkg::LINE_W-1:0]      mem_ret_data_i
);

    icache_pkg::lookup_req_t        lookup;
    icache_pkg::way_hit_t           hit;
    icache_pkg::refill_wr_t         wr;
    logic                           hold;
    logic [icache_pkg::INDEX_W-1:0] rd_index_a;
    logic [icache_pkg::INDEX_W-1:0] rd_index_b;

    fetch_request fetch_request_inst (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid_i(fetch_valid_i),
        .pc_i         (pc_i),
        .flush_i      (flush_i),
        .hold_i       (hold),
        .lookup_o     (lookup),
        .rd_index_a_o (rd_index_a),
        .rd_index_b_o (rd_index_b)
    );

    cache_ways cache_ways_inst (
        .clk         (clk),
        .reset       (reset),
        .rd_index_a_i(rd_index_a),
        .rd_index_b_i(rd_index_b),
        .lookup_i    (lookup),
        .wr_i        (wr),
        .hit_o       (hit)
    );

    refill_ctrl refill_ctrl_inst (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (flush_i),
        .lookup_i       (lookup),
        .hit_i          (hit),
        .mem_ret_valid_i(mem_ret_valid_i),
        .mem_ret_data_i (mem_ret_data_i),
        .mem_req_o      (mem_req_o),
        .wr_o           (wr),
        .hold_o         (hold),
        .stall_o        (stall_o),
        .inst_valid_o   (inst_valid_o),
        .inst_o         (inst_o),
        .inst_pc_o      (inst_pc_o)
    );

endmodule

//--- design/refill_ctrl.sv
module refill_ctrl (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   flush_i,
    input  icache_pkg::lookup_req_t                lookup_i,
    input  icache_pkg::way_hit_t                   hit_i,
    input  logic                                   mem_ret_valid_i,
    input  logic [icache_pkg::LINE_W-1:0]          mem_ret_data_i,
    output icache_pkg::mem_req_t                   mem_req_o,
    output icache_pkg::refill_wr_t                 wr_o,
    output logic                                   hold_o,
    output logic                                   stall_o,
    output logic                                   inst_valid_o,
    output logic [1:0][icache_pkg::ADDR_W-1:0]     inst_o,
    output logic [1:0][icache_pkg::ADDR_W-1:0]     inst_pc_o
);

    icache_pkg::refill_state_e        state_q;
    icache_pkg::refill_state_e        state_d;
    icache_pkg::fetch_addr_u          fill_addr;
    icache_pkg::fetch_addr_u          line_addr;
    logic [icache_pkg::NUM_SETS-1:0]  lru_q;
    logic [icache_pkg::INDEX_W-1:0]   fill_index;
    logic                             hit_a;
    logic                             hit_b;
    logic                             same_line;
    logic                             filling;
    logic                             drop_q;
    logic                             ret_ok;
    logic                             victim;
    logic                             deliver_now;

    assign hit_a     = |hit_i.hit_a;
    assign hit_b     = |hit_i.hit_b;
    assign same_line = (lookup_i.pair.a.f.tag == lookup_i.pair.b.f.tag) &&
                       (lookup_i.pair.a.f.index == lookup_i.pair.b.f.index);
    assign filling   = (state_q == icache_pkg::state_fill_a) ||
                       (state_q == icache_pkg::state_fill_b);

    // a return owed to a flushed fetch is swallowed
    always_ff @(posedge clk) begin
        if (reset || mem_ret_valid_i) begin
            drop_q <= 1'b0;
        end else if (flush_i && mem_req_o.req) begin
            drop_q <= 1'b1;
        end
    end

    assign ret_ok = mem_ret_valid_i && !drop_q && !flush_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::state_idle: begin
                if (lookup_i.valid && !hit_a) begin
                    state_d = icache_pkg::state_fill_a;
                end else if (lookup_i.valid && !hit_b) begin
                    state_d = icache_pkg::state_fill_b;
                end
            end
            icache_pkg::state_fill_a: begin
                if (ret_ok) begin
                    state_d = (hit_b || same_line) ? icache_pkg::state_deliver
                                                   : icache_pkg::state_fill_b;
                end
            end
            icache_pkg::state_fill_b: begin
                if (ret_ok) begin
                    state_d = icache_pkg::state_deliver;
                end
            end
            // one cycle for the arrays to re-read the new line
            icache_pkg::state_deliver: state_d = icache_pkg::state_idle;
            default: state_d = icache_pkg::state_idle;
        endcase
        if (flush_i) begin
            state_d = icache_pkg::state_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= icache_pkg::state_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign stall_o = (state_q != icache_pkg::state_idle) ||
                     (lookup_i.valid && !(hit_a && hit_b));
    assign hold_o  = stall_o;

    always_comb begin
        fill_addr = (state_q == icache_pkg::state_fill_b) ? lookup_i.pair.b : lookup_i.pair.a;
        line_addr = fill_addr;
        line_addr.f.word_sel = '0;
        line_addr.f.offset   = '0;
    end

    assign fill_index = fill_addr.f.index;
    assign victim     = lru_q[fill_index];

    assign mem_req_o.req  = filling && !drop_q;
    assign mem_req_o.addr = line_addr.raw;

    always_comb begin
        wr_o.we   = ret_ok && filling;
        wr_o.way  = victim;
        wr_o.we_a = state_q == icache_pkg::state_fill_a;
        wr_o.we_b = (state_q == icache_pkg::state_fill_b) ||
                    ((state_q == icache_pkg::state_fill_a) && same_line);
        wr_o.line = mem_ret_data_i;
    end

    // bit names the next victim
    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else begin
            if ((state_q == icache_pkg::state_idle) && lookup_i.valid) begin
                if (hit_a) begin
                    lru_q[lookup_i.pair.a.f.index] <= hit_i.hit_a[0];
                end
                if (hit_b) begin
                    lru_q[lookup_i.pair.b.f.index] <= hit_i.hit_b[0];
                end
            end
            if (wr_o.we) begin
                lru_q[fill_index] <= ~victim;
            end
        end
    end

    assign deliver_now = (state_q == icache_pkg::state_idle) && lookup_i.valid &&
                         hit_a && hit_b;

    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            inst_valid_o <= 1'b0;
        end else begin
            inst_valid_o <= deliver_now;
        end
    end

    always_ff @(posedge clk) begin
        if (deliver_now) begin
            inst_o[0]    <= hit_i.data_a;
            inst_o[1]    <= hit_i.data_b;
            inst_pc_o[0] <= lookup_i.pair.a.raw;
            inst_pc_o[1] <= lookup_i.pair.b.raw;
        end
    end

    a_state_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot(state_q)
    ) else $error("refill state not one-hot");

    a_req_addr_stable: assert property (
        @(posedge clk) disable iff (reset)
        mem_req_o.req && !mem_ret_valid_i && !flush_i |=> $stable(mem_req_o.addr)
    ) else $error("memory request address changed before return");

endmodule

//--- tb/icache_tb.sv
module icache_tb;

    localparam int          CLK_PERIOD      = 20;
    localparam int          RESET_CYCLES    = 8;
    localparam int          NUM_FETCHES     = 29;
    localparam int          WATCHDOG_CYCLES = RESET_CYCLES + NUM_FETCHES * (8 + 10);
    localparam logic [31:0] MEM_PATTERN     = 32'h5a3c_96e1;

    logic                                clk;
    logic                                reset;
    logic                                fetch_valid;
    logic [31:0]                         pc;
    logic                                flush;
    logic                                stall;
    logic                                inst_valid;
    logic [1:0][31:0]                    inst;
    logic [1:0][31:0]                    inst_pc;
    icache_pkg::mem_req_t                mem_req;
    logic                                mem_ret_valid;
    logic [icache_pkg::LINE_W-1:0]       mem_ret_data;
    int                                  req_count;
    logic [31:0]                         last_addr;
    logic [31:0]                         req_log[$];
    int                                  seen_count = 0;

    tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_inst (.clk_o(clk));

    icache_top icache_top_inst (
        .clk            (clk),
        .reset          (reset),
        .fetch_valid_i  (fetch_valid),
        .pc_i           (pc),
        .flush_i        (flush),
        .stall_o        (stall),
        .inst_valid_o   (inst_valid),
        .inst_o         (inst),
        .inst_pc_o      (inst_pc),
        .mem_req_o      (mem_req),
        .mem_ret_valid_i(mem_ret_valid),
        .mem_ret_data_i (mem_ret_data)
    );

    mem_model #(.MEM_PATTERN(MEM_PATTERN)) mem_model_inst (
        .clk            (clk),
        .reset          (reset),
        .mem_req_i      (mem_req),
        .mem_ret_valid_o(mem_ret_valid),
        .mem_ret_data_o (mem_ret_data),
        .req_count_o    (req_count),
        .last_addr_o    (last_addr)
    );

    // log every line address memory takes
    always @(negedge clk) begin
        if (req_count != seen_count) begin
            req_log.push_back(last_addr);
            seen_count = req_count;
        end
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "run stopped after an error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            stop_run();
        end
    endtask

    function automatic logic [31:0] make_pc(input logic [19:0] tag, input logic [6:0] index,
                                            input logic [2:0] word);
        return {tag, index, word, 2'b00};
    endfunction

    // holds the request until the cache takes it on the next edge
    task automatic drive_fetch(input logic [31:0] fetch_pc);
        @(posedge clk);
        fetch_valid <= 1'b1;
        pc          <= fetch_pc;
        @(negedge clk);
        while (stall) @(negedge clk);
    endtask

    task automatic end_fetch();
        @(posedge clk);
        fetch_valid <= 1'b0;
    endtask

    task automatic wait_result();
        @(negedge clk);
        while (!inst_valid) @(negedge clk);
    endtask

    task automatic check_pair(input logic [31:0] fetch_pc);
        expect_equal("inst_o[0]", inst[0], fetch_pc ^ MEM_PATTERN);
        expect_equal("inst_o[1]", inst[1], (fetch_pc + 32'd4) ^ MEM_PATTERN);
        expect_equal("inst_pc_o[0]", inst_pc[0], fetch_pc);
        expect_equal("inst_pc_o[1]", inst_pc[1], fetch_pc + 32'd4);
    endtask

    task automatic fetch_and_check(input logic [31:0] fetch_pc);
        drive_fetch(fetch_pc);
        end_fetch();
        wait_result();
        check_pair(fetch_pc);
    endtask

    task automatic test_cold_miss();
        logic [31:0] fetch_pc;
        int          base_count;
        fetch_pc   = make_pc(20'($urandom()), 7'h10, 3'($urandom_range(6, 0)));
        base_count = req_count;
        drive_fetch(fetch_pc);
        end_fetch();
        // lookup cycle of the missing request
        @(negedge clk);
        expect_equal("stall_o", 32'(stall), 32'd1);
        wait_result();
        check_pair(fetch_pc);
        expect_equal("mem request count", 32'(req_count - base_count), 32'd1);
        expect_equal("mem request addr", req_log[req_log.size() - 1],
                     {fetch_pc[31:5], 5'b0});
    endtask

    task automatic test_hit_stream();
        logic [31:0] base_pc;
        logic [31:0] pcs[8];
        int          base_count;
        base_pc = make_pc(20'($urandom()), 7'h20, 3'd0);
        fetch_and_check(base_pc);
        base_count = req_count;
        for (int k = 0; k < 8; k++) begin
            pcs[k] = base_pc + 32'(4 * $urandom_range(6, 0));
        end
        fork
            begin
                for (int k = 0; k < 8; k++) begin
                    drive_fetch(pcs[k]);
                end
                end_fetch();
            end
            begin
                wait_result();
                // one result on each cycle, in order
                for (int k = 0; k < 8; k++) begin
                    expect_equal("inst_valid_o", 32'(inst_valid), 32'd1);
                    check_pair(pcs[k]);
                    if (k < 7) begin
                        @(negedge clk);
                    end
                end
            end
        join
        expect_equal("mem request count", 32'(req_count - base_count), 32'd0);
    endtask

    task automatic test_line_cross();
        logic [31:0] fetch_pc;
        logic [31:0] line_a;
        int          base_count;
        int          base_log;
        fetch_pc   = make_pc(20'($urandom()), 7'h30, 3'd7);
        line_a     = {fetch_pc[31:5], 5'b0};
        base_count = req_count;
        base_log   = req_log.size();
        fetch_and_check(fetch_pc);
        expect_equal("mem request count", 32'(req_count - base_count), 32'd2);
        expect_equal("first request addr", req_log[base_log], line_a);
        expect_equal("second request addr", req_log[base_log + 1], line_a + 32'd32);
    endtask

    task automatic test_replacement();
        logic [19:0] tag;
        logic [31:0] pc_x;
        logic [31:0] pc_y;
        logic [31:0] pc_z;
        int          base_count;
        tag        = 20'($urandom());
        pc_x       = make_pc(tag, 7'h40, 3'd0);
        pc_y       = make_pc(tag ^ 20'h1, 7'h40, 3'd0);
        pc_z       = make_pc(tag ^ 20'h2, 7'h40, 3'd0);
        base_count = req_count;
        fetch_and_check(pc_x);
        fetch_and_check(pc_y);
        expect_equal("mem request count", 32'(req_count - base_count), 32'd2);
        fetch_and_check(pc_x);
        expect_equal("mem request count", 32'(req_count - base_count), 32'd2);
        // y is least recently used and gets evicted
        fetch_and_check(pc_z);
        fetch_and_check(pc_x);
        expect_equal("mem request count", 32'(req_count - base_count), 32'd3);
        fetch_and_check(pc_y);
        expect_equal("mem request count", 32'(req_count - base_count), 32'd4);
    endtask

    task automatic test_flush_refill();
        logic [19:0] tag;
        logic [31:0] fetch_pc;
        logic [31:0] next_pc;
        int          base_count;
        for (int k = 0; k < 4; k++) begin
            tag        = 20'($urandom());
            fetch_pc   = make_pc(tag, 7'h50 + 7'(k), 3'($urandom_range(6, 0)));
            next_pc    = make_pc(tag ^ 20'h1, 7'h50 + 7'(k), 3'($urandom_range(6, 0)));
            base_count = req_count;
            drive_fetch(fetch_pc);
            end_fetch();
            @(negedge clk);
            while (!mem_req.req) @(negedge clk);
            @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
            // the flushed line may still be in flight during this refill
            fetch_and_check(next_pc);
            expect_equal("mem request count", 32'(req_count - base_count), 32'd2);
            // dropped line must not have been written
            fetch_and_check(fetch_pc);
            expect_equal("mem request count", 32'(req_count - base_count), 32'd3);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        stop_run();
    end

    initial begin
        reset       = 1'b1;
        fetch_valid = 1'b0;
        pc          = '0;
        flush       = 1'b0;
        void'($urandom(32'h13b5_ccbf));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        test_cold_miss();
        test_hit_stream();
        test_line_cross();
        test_replacement();
        test_flush_refill();
        repeat (2) @(posedge clk);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- tb/mem_model.sv
module mem_model #(
    parameter logic [31:0] MEM_PATTERN = 32'h0
) (
    input  logic                          clk,
    input  logic                          reset,
    input  icache_pkg::mem_req_t          mem_req_i,
    output logic                          mem_ret_valid_o,
    output logic [icache_pkg::LINE_W-1:0] mem_ret_data_o,
    output int                            req_count_o,
    output logic [31:0]                   last_addr_o
);

    logic busy;
    int   wait_cnt;

    initial begin
        mem_ret_valid_o = 1'b0;
        mem_ret_data_o  = '0;
        req_count_o     = 0;
        last_addr_o     = '0;
        busy            = 1'b0;
        wait_cnt        = 0;
    end

    // one request at a time, latency 1 to 8 cycles
    always @(posedge clk) begin
        if (reset) begin
            mem_ret_valid_o <= 1'b0;
            busy            <= 1'b0;
            req_count_o     <= 0;
        end else begin
            mem_ret_valid_o <= 1'b0;
            if (busy) begin
                if (wait_cnt == 1) begin
                    mem_ret_valid_o <= 1'b1;
                    for (int k = 0; k < icache_pkg::WORDS_PER_LINE; k++) begin
                        mem_ret_data_o[32*k +: 32] <= (last_addr_o + 32'(4 * k)) ^ MEM_PATTERN;
                    end
                    busy <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (mem_req_i.req && !mem_ret_valid_o) begin
                busy        <= 1'b1;
                wait_cnt    <= int'($urandom_range(8, 1));
                last_addr_o <= mem_req_i.addr;
                req_count_o <= req_count_o + 1;
            end
        end
    end

endmodule

//--- tb/tb_clock.sv
module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule
